/* flist.f */
+incdir+common
common/capture_pkg.sv
common/capture_if.sv
capture/signal_capture.sv
capture/align_captures.sv
rtl/capture_top.sv
bench/capture_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the capture front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f flist.f --top-module capture_tb \
   -Mdir "$BUILD_DIR" -o capture_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/capture_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q -F '*** TEST PASSED ***' "$LOG"; then
   exit 0
fi
exit 1

/* bench/capture_tb.sv */
`timescale 1ns/100ps
`include "capture_cfg.svh"

module capture_tb;

   localparam int RATE       = `CAP_CLOCK_RATE;
   localparam int NSIG       = `CAP_NUM_SIGNALS;
   // Bits sent over the whole run, sizes the word store and the watchdog
   localparam int TOTAL_BITS = 240;

   logic                  clk;
   logic                  rst;
   logic                  ce;
   logic [NSIG-1:0]       raw;
   logic                  ack;
   capture_pkg::sig_vec_t data_out;
   logic                  ready;
   logic                  locked;
   logic                  invalid;

   // Stimulus state
   logic [31:0]           lfsr;
   capture_pkg::sig_vec_t words [TOTAL_BITS];
   int                    skew [NSIG];
   int                    tick_n;
   int                    stall_left;
   bit                    stall_en;
   bit                    ack_req;
   int                    glitch_tick;
   int                    glitch_ant;
   // Checker state
   bit                    word_check;
   bit                    synced;
   bit                    hold_invalid;
   int                    next_idx;
   int                    ready_count;
   int                    error_count;
   int                    test_errors;
   int                    pass_count;
   int                    fail_count;

   capture_top dut (
      .clk      (clk),
      .rst      (rst),
      .ce       (ce),
      .raw      (raw),
      .ack      (ack),
      .data_out (data_out),
      .ready    (ready),
      .locked   (locked),
      .invalid  (invalid)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Four clocks per tick covers the ce stalls with room to spare
   initial begin
      repeat (TOTAL_BITS * RATE * 4 + 1000) @(posedge clk);
      $display("timeout: the tests did not finish in the expected number of cycles");
      $display("*** TEST FAILED ***");
      $finish;
   end

   // ------------------------------
   // Stimulus helpers
   // ------------------------------

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] next_random(int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   // Antenna i shows bit k of every word, delayed by its own skew
   function automatic capture_pkg::sig_vec_t stream_at(int t);
      capture_pkg::sig_vec_t v;
      int                    idx;
      v = '0;
      for (int i = 0; i < NSIG; i++) begin
         idx = (t - skew[i]) / RATE;
         if (t >= skew[i] && idx < TOTAL_BITS) begin
            v[i] = words[idx][i];
         end
      end
      // One-tick glitch in the middle of a bit
      if (t == glitch_tick) begin
         v[glitch_ant] = ~v[glitch_ant];
      end
      return v;
   endfunction

   task automatic note_error(string msg);
      $display("error at time %0t: %s", $time, msg);
      error_count++;
   endtask

   task automatic check_word(string name, capture_pkg::sig_vec_t exp,
                             capture_pkg::sig_vec_t act);
      if (act !== exp) begin
         $display("mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
         error_count++;
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("mismatch at time %0t: %s expected %b actual %b", $time, name, exp, act);
         error_count++;
      end
   endtask

   // ------------------------------
   // Per-cycle watch and drive
   // ------------------------------

   task automatic watch_outputs();
      int j;
      // ce still holds the value the last rising edge used
      if (!ce) begin
         check_flag("ready", 1'b0, ready);
      end
      if (hold_invalid) begin
         check_flag("invalid", 1'b1, invalid);
      end
      if (ready) begin
         ready_count++;
      end
      if (ready && word_check) begin
         if (!synced) begin
            // Latest matching word starts the sequence
            for (j = 0; j <= tick_n / RATE && j < TOTAL_BITS; j++) begin
               if (words[j] == data_out) begin
                  next_idx = j + 1;
                  synced   = 1'b1;
               end
            end
            if (!synced) begin
               note_error("ready word matches no transmitted word");
            end
         end else begin
            check_word("data_out", words[next_idx], data_out);
            next_idx++;
         end
      end
   endtask

   task automatic drive_inputs();
      if (stall_left > 0) begin
         stall_left--;
         ce = 1'b0;
      end else if (stall_en && next_random(3) == 32'd0) begin
         // Stall of 1 to 8 cycles
         stall_left = int'(next_random(3));
         ce         = 1'b0;
      end else begin
         ce  = 1'b1;
         raw = stream_at(tick_n);
         tick_n++;
      end
      // ack only rides on a ce cycle
      ack = ack_req && ce;
      if (ack) begin
         ack_req = 1'b0;
      end
   endtask

   task automatic step_cycle();
      @(negedge clk);
      watch_outputs();
      drive_inputs();
   endtask

   task automatic run_ticks(int n);
      int target;
      target = tick_n + n;
      while (tick_n < target) begin
         step_cycle();
      end
   endtask

   task automatic wait_for_lock(int max_ticks);
      int limit;
      limit = tick_n + max_ticks;
      while (locked !== 1'b1 && tick_n < limit) begin
         step_cycle();
      end
      if (locked !== 1'b1) begin
         note_error("locked did not rise within the expected number of bits");
      end
   endtask

   task automatic wait_for_invalid(int max_ticks);
      int limit;
      limit = tick_n + max_ticks;
      while (invalid !== 1'b1 && tick_n < limit) begin
         step_cycle();
      end
      if (invalid !== 1'b1) begin
         note_error("invalid did not rise after the fault was injected");
      end
   endtask

   task automatic close_test(int num, string name);
      if (error_count == test_errors) begin
         $display("test %0d %s: pass", num, name);
         pass_count++;
      end else begin
         $display("test %0d %s: fail with %0d errors", num, name, error_count - test_errors);
         fail_count++;
      end
      test_errors = error_count;
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial begin
      logic [31:0] rnd;
      int          sel;
      lfsr         = 32'h243af37e;
      rst          = 1'b1;
      ce           = 1'b0;
      raw          = '0;
      ack          = 1'b0;
      tick_n       = 0;
      stall_left   = 0;
      stall_en     = 1'b0;
      ack_req      = 1'b0;
      glitch_tick  = -1;
      glitch_ant   = 0;
      word_check   = 1'b0;
      synced       = 1'b0;
      hold_invalid = 1'b0;
      next_idx     = 0;
      ready_count  = 0;
      error_count  = 0;
      test_errors  = 0;
      pass_count   = 0;
      fail_count   = 0;
      for (int k = 0; k < TOTAL_BITS; k++) begin
         rnd      = next_random(NSIG);
         words[k] = rnd[NSIG-1:0];
      end
      for (int i = 0; i < NSIG; i++) begin
         rnd     = next_random(2);
         skew[i] = int'(rnd[1:0]);
      end
      repeat (8) @(negedge clk);
      rst = 1'b0;

      // Flags stay low over the first bit and a half
      while (tick_n < RATE + RATE / 2) begin
         step_cycle();
         check_flag("ready", 1'b0, ready);
         check_flag("locked", 1'b0, locked);
         check_flag("invalid", 1'b0, invalid);
      end
      close_test(1, "quiet after reset");

      word_check = 1'b1;
      wait_for_lock(40 * RATE);
      run_ticks(2 * RATE);
      // Clear anything flagged while the antennas were settling
      ack_req = 1'b1;
      run_ticks(2 * RATE);
      check_flag("invalid", 1'b0, invalid);
      ready_count = 0;
      run_ticks(30 * RATE);
      check_flag("locked", 1'b1, locked);
      check_flag("invalid", 1'b0, invalid);
      if (!synced || ready_count < 29) begin
         note_error("ready pulses missing during the clean stream");
      end
      close_test(2, "clean skewed stream");

      stall_en    = 1'b1;
      ready_count = 0;
      run_ticks(40 * RATE);
      stall_en = 1'b0;
      check_flag("locked", 1'b1, locked);
      check_flag("invalid", 1'b0, invalid);
      if (ready_count < 39) begin
         note_error("ready pulses missing across the ce stalls");
      end
      close_test(3, "ce stalls");

      // Glitch four ticks into a bit of one antenna
      word_check  = 1'b0;
      synced      = 1'b0;
      rnd         = next_random(5);
      glitch_ant  = int'(rnd[4:0]) % NSIG;
      glitch_tick = (tick_n / RATE + 2) * RATE + skew[glitch_ant] + 4;
      wait_for_invalid(4 * RATE);
      hold_invalid = 1'b1;
      run_ticks(30 * RATE);
      hold_invalid = 1'b0;
      wait_for_lock(20 * RATE);
      run_ticks(2 * RATE);
      ack_req = 1'b1;
      while (ack_req) begin
         step_cycle();
      end
      step_cycle();
      check_flag("invalid", 1'b0, invalid);
      word_check  = 1'b1;
      ready_count = 0;
      run_ticks(10 * RATE);
      check_flag("invalid", 1'b0, invalid);
      if (!synced || ready_count < 9) begin
         note_error("word sequence did not resume after the ack");
      end
      close_test(4, "glitch and ack");

      // One antenna moved into the quiet gap
      word_check = 1'b0;
      check_flag("locked", 1'b1, locked);
      rnd        = next_random(5);
      sel        = int'(rnd[4:0]) % NSIG;
      skew[sel]  = `CAP_CLEAR_GAP + 1;
      // The shift itself is an off-phase edge, let the antenna relock
      wait_for_invalid(12 * RATE);
      run_ticks(8 * RATE);
      ack_req = 1'b1;
      while (ack_req) begin
         step_cycle();
      end
      // Late strobes alone must raise invalid again while still locked
      wait_for_invalid(4 * RATE);
      check_flag("locked", 1'b1, locked);
      close_test(5, "late antenna");

      $display("tests passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* rtl/capture_top.sv */
`timescale 1ns/100ps
`include "capture_cfg.svh"

module capture_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        ce,
   input  logic [`CAP_NUM_SIGNALS-1:0] raw,
   input  logic                        ack,
   output logic [`CAP_NUM_SIGNALS-1:0] data_out,
   output logic                        ready,
   output logic                        locked,
   output logic                        invalid
);

   // ------------------------------
   // Per-antenna capture outputs
   // ------------------------------

   capture_if caps ();

   // One edge tracker per antenna stream
   // each drives its own bit of the shared vectors
   for (genvar i = 0; i < `CAP_NUM_SIGNALS; i++) begin : g_capture
      signal_capture #(
         .SIG_INDEX (i)
      ) u_capture (
         .clk (clk),
         .rst (rst),
         .ce  (ce),
         .raw (raw[i]),
         .cap (caps.capture)
      );
   end

   // ------------------------------
   // Alignment across antennas
   // ------------------------------

   // Collects one bit period of strobes into the aligned word
   align_captures u_align (
      .clk      (clk),
      .rst      (rst),
      .ce       (ce),
      .caps     (caps.align),
      .ack      (ack),
      .data_out (data_out),
      .ready    (ready),
      .locked   (locked),
      .invalid  (invalid)
   );

endmodule

/* capture/align_captures.sv */
`timescale 1ns/100ps
`include "capture_cfg.svh"

module align_captures (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  ce,
   capture_if.align              caps,
   input  logic                  ack,
   output capture_pkg::sig_vec_t data_out,
   output logic                  ready,
   output logic                  locked,
   output logic                  invalid
);

   localparam capture_pkg::count_t CLEAR_GAP  = capture_pkg::count_t'(`CAP_CLEAR_GAP);
   localparam capture_pkg::count_t STROBE_GAP = capture_pkg::count_t'(`CAP_STROBE_GAP);
   localparam capture_pkg::count_t COUNT_MAX  = '1;
   localparam capture_pkg::count_t COUNT_STEP = capture_pkg::count_t'(1);

   // Reduced views of the per-antenna vectors
   logic                  strobe_w;
   logic                  locked_w;
   // Registered OR of the strobes
   logic                  strobe;
   // Collecting the strobes of one bit period
   logic                  window;
   // Ticks since the window opened
   capture_pkg::count_t   count;
   // Quiet ticks since the last window
   capture_pkg::count_t   clear;
   // Strobes seen so far in this window
   capture_pkg::sig_vec_t strobes_reg;
   capture_pkg::sig_vec_t strobes_base;
   capture_pkg::sig_vec_t strobes_upd;
   // Previous tick completed a window
   logic                  strobes_all;
   logic                  strobes_end;
   logic                  clear_valid;
   // Error sources
   logic                  has_overlaps;
   logic                  invalid_input;
   logic                  too_much_spread;
   logic                  too_wide;
   logic                  capture_error;

   assign strobe_w = |caps.strobes;
   assign locked_w = &caps.lockeds;

   // ------------------------------
   // Strobe accumulation
   // ------------------------------

   // A completed window restarts from empty on the next tick
   assign strobes_base = strobes_all ? '0 : strobes_reg;
   assign strobes_upd  = strobes_base | caps.strobes;
   assign strobes_end  = &strobes_upd;

   always_ff @(posedge clk) begin
      if (rst) begin
         strobe <= 1'b0;
      end else if (ce) begin
         strobe <= strobe_w;
      end
   end

   // strobes_all pulses for one ce tick per completed window
   always_ff @(posedge clk) begin
      if (rst) begin
         strobes_reg <= '0;
         strobes_all <= 1'b0;
      end else if (ce) begin
         strobes_reg <= strobes_upd;
         strobes_all <= strobes_end;
      end
   end

   // ------------------------------
   // Window and gap counters
   // ------------------------------

   // Opens on any strobe, closes once every antenna has strobed
   always_ff @(posedge clk) begin
      if (rst) begin
         window <= 1'b0;
      end else if (ce) begin
         if (strobes_end) begin
            window <= 1'b0;
         end else if (strobe_w) begin
            window <= 1'b1;
         end
      end
   end

   // Both counters saturate so a long idle stretch never wraps
   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else if (ce) begin
         if (!window) begin
            count <= '0;
         end else if (count != COUNT_MAX) begin
            count <= count + COUNT_STEP;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         clear <= '0;
      end else if (ce) begin
         if (strobe || window) begin
            clear <= '0;
         end else if (clear != COUNT_MAX) begin
            clear <= clear + COUNT_STEP;
         end
      end
   end

   // ------------------------------
   // Lock and output word
   // ------------------------------

   // First strobe after a full quiet gap samples the antenna locks
   assign clear_valid = strobe && (clear >= CLEAR_GAP);

   always_ff @(posedge clk) begin
      if (rst) begin
         locked <= 1'b0;
      end else if (ce && clear_valid) begin
         locked <= locked_w;
      end
   end

   // One ready per completed window, low whenever ce is low
   always_ff @(posedge clk) begin
      if (rst) begin
         ready <= 1'b0;
      end else begin
         ready <= ce && strobes_all && locked;
      end
   end

   always_ff @(posedge clk) begin
      if (ce && strobes_all && locked) begin
         data_out <= caps.data;
      end
   end

   // ------------------------------
   // Invalid detection
   // ------------------------------

   // Same antenna strobing twice in one window
   assign has_overlaps    = |(strobes_base & caps.strobes);
   assign invalid_input   = |caps.invalids;
   // Strobe arriving inside the quiet gap
   assign too_much_spread = locked_w && strobe && (clear != '0) && (clear < CLEAR_GAP);
   // window still open past the allowed spread
   assign too_wide        = window && (count >= STROBE_GAP);
   assign capture_error   = has_overlaps || invalid_input || too_much_spread || too_wide;

   // Sticky until an ack lands on a ce tick
   always_ff @(posedge clk) begin
      if (rst) begin
         invalid <= 1'b0;
      end else if (ce) begin
         invalid <= (invalid && !ack) || (locked && capture_error);
      end
   end

endmodule

/* capture/signal_capture.sv */
`timescale 1ns/100ps
`include "capture_cfg.svh"

module signal_capture #(
   parameter int SIG_INDEX = 0
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       ce,
   input  logic       raw,
   capture_if.capture cap
);

   // Phase value seen on the tick where the next edge is due
   localparam capture_pkg::phase_t PHASE_LAST =
      capture_pkg::phase_t'(`CAP_CLOCK_RATE - 1);
   // One tick early still counts as on time
   localparam capture_pkg::phase_t PHASE_NEAR =
      capture_pkg::phase_t'(`CAP_CLOCK_RATE - 2);
   // Strobe register loads here, so it shows CLOCK_RATE/2 ticks after the edge
   localparam capture_pkg::phase_t PHASE_MID =
      capture_pkg::phase_t'(`CAP_CLOCK_RATE / 2 - 1);
   localparam capture_pkg::phase_t PHASE_STEP = capture_pkg::phase_t'(1);

   // Previous sample of the stream
   logic                raw_q;
   // Transition between previous and current sample
   logic                raw_edge;
   // Edge lands within one tick of the expected phase
   logic                good_w;
   // Mid-bit sampling point
   logic                mid_w;
   // Ticks since the last edge, free running between edges
   capture_pkg::phase_t phase;
   // Last edge was on time
   logic                good_prev;
   logic                locked_q;
   logic                invalid_q;
   logic                strobe_q;
   // Sampled bit
   logic                data_q;

   // ------------------------------
   // Edge detection
   // ------------------------------

   assign raw_edge = raw ^ raw_q;

   // Window of +/- one tick around the expected edge
   // phase wraps to 0 after PHASE_LAST, so 0 is one tick late
   assign good_w = (phase == PHASE_NEAR) ||
                   (phase == PHASE_LAST) ||
                   (phase == '0);

   // No sample on an edge tick, the stream is mid-transition there
   assign mid_w = (phase == PHASE_MID) && !raw_edge;

   always_ff @(posedge clk) begin
      if (rst) begin
         raw_q <= 1'b0;
      end else if (ce) begin
         raw_q <= raw;
      end
   end

   // ------------------------------
   // Phase counter
   // ------------------------------

   // Any edge realigns the counter, otherwise it wraps once per bit
   // so runs of equal bits keep the same timing
   always_ff @(posedge clk) begin
      if (rst) begin
         phase <= '0;
      end else if (ce) begin
         if (raw_edge || phase == PHASE_LAST) begin
            phase <= '0;
         end else begin
            phase <= phase + PHASE_STEP;
         end
      end
   end

   // ------------------------------
   // Lock tracking
   // ------------------------------

   // Two on-time edges in a row give lock
   // An off-phase edge while locked drops lock and flags the antenna
   always_ff @(posedge clk) begin
      if (rst) begin
         good_prev <= 1'b0;
         locked_q  <= 1'b0;
         invalid_q <= 1'b0;
      end else if (ce) begin
         // invalid is a single ce tick pulse
         invalid_q <= 1'b0;
         if (raw_edge) begin
            good_prev <= good_w;
            if (good_w && good_prev) begin
               locked_q <= 1'b1;
            end else if (!good_w) begin
               locked_q  <= 1'b0;
               invalid_q <= locked_q;
            end
         end
      end
   end

   // ------------------------------
   // Mid-bit sampling
   // ------------------------------

   // Strobe lasts exactly one ce tick
   always_ff @(posedge clk) begin
      if (rst) begin
         strobe_q <= 1'b0;
      end else if (ce) begin
         strobe_q <= mid_w;
      end
   end

   // Data holds until the next strobe of this antenna
   always_ff @(posedge clk) begin
      if (ce && mid_w) begin
         data_q <= raw;
      end
   end

   // Drive this antenna's bit of the shared vectors
   assign cap.data[SIG_INDEX]     = data_q;
   assign cap.strobes[SIG_INDEX]  = strobe_q;
   assign cap.lockeds[SIG_INDEX]  = locked_q;
   assign cap.invalids[SIG_INDEX] = invalid_q;

endmodule

/* common/capture_if.sv */
`timescale 1ns/100ps

interface capture_if;

   // Mid-bit samples, one per antenna
   // each bit holds until that antenna strobes again
   capture_pkg::sig_vec_t data;

   // One ce tick pulse per sampled bit
   capture_pkg::sig_vec_t strobes;

   // Per-antenna phase lock level
   capture_pkg::sig_vec_t lockeds;

   // One ce tick pulse on an off-phase edge
   capture_pkg::sig_vec_t invalids;

   // Each capture block drives its own bit of every vector
   modport capture (
      output data,
      output strobes,
      output lockeds,
      output invalids
   );

   // The aligner only observes
   modport align (
      input data,
      input strobes,
      input lockeds,
      input invalids
   );

endinterface

/* common/capture_pkg.sv */
package capture_pkg;

`include "capture_cfg.svh"

   // ------------------------------
   // Shared capture types
   // ------------------------------

   // One bit per antenna
   typedef logic [`CAP_NUM_SIGNALS-1:0] sig_vec_t;

   // Tick position within one bit period
   typedef logic [`CAP_BITS_COUNT-1:0] phase_t;

   // Window length and quiet gap counts
   typedef logic [`CAP_BITS_COUNT-1:0] count_t;

endpackage

/* common/capture_cfg.svh */
`ifndef CAPTURE_CFG_SVH
`define CAPTURE_CFG_SVH

// ------------------------------
// Capture front end sizing
// ------------------------------

// Number of antenna streams
`define CAP_NUM_SIGNALS 24

// Supersample ticks per bit
`define CAP_CLOCK_RATE 12

// Minimum quiet ticks between acquisition windows
`define CAP_CLEAR_GAP 7

// Largest tolerated strobe spread within one window
`define CAP_STROBE_GAP 5

// Width of the phase and tick counters
`define CAP_BITS_COUNT 4

`endif
